/* vlog.f */
logic/taint_pkg.sv
logic/taint_decode.sv
logic/taint_execute.sv
logic/taint_result.sv
logic/taint_unit.sv
dv/taint_unit_checker.sv
dv/taint_unit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the taint_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module taint_unit_tb -f vlog.f -o taint_unit_sim

# a simulator error exit also stops the script
./obj_dir/taint_unit_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0

/* dv/taint_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module taint_unit_tb;

    localparam int w = taint_pkg::data_width_default;
    localparam int clk_period = 8;
    localparam logic [w-1:0] amt_mask = w - 1;
    // untainted, binary, reduce, mux, fold, reset
    localparam int total_ops = 60 + 52 + 24 + 16 + 24 + 8;

    logic                   pos_clk;
    logic                   pos_arst;
    logic                   op_valid;
    taint_pkg::taint_op_t   op;
    logic                   res_valid;
    taint_pkg::taint_word_t res;
    taint_pkg::taint_word_t acc;

    logic [31:0]            rng_state = 32'h18e3;
    int                     value_errors = 0;
    int                     protocol_errors = 0;
    taint_pkg::taint_word_t model_acc;
    taint_pkg::taint_word_t exp_res_q[$];
    taint_pkg::taint_word_t exp_acc_q[$];

    taint_unit #(
        .data_width (w)
    ) i_taint_unit (
        .pos_clk   (pos_clk),
        .pos_arst  (pos_arst),
        .op_valid  (op_valid),
        .op        (op),
        .res_valid (res_valid),
        .res       (res),
        .acc       (acc)
    );

    initial begin
        pos_clk = 1'b0;
        forever #(clk_period / 2) pos_clk = ~pos_clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [w-1:0] rand_word();
        logic [31:0] r;
        r = next_rand();
        return r[w-1:0];
    endfunction

    // arithmetic right shift, fill with the top bit
    function automatic logic [w-1:0] shift_arith(logic [w-1:0] x, int amt);
        return (x >> amt) | (~({w{1'b1}} >> amt) & {w{x[w-1]}});
    endfunction

    // expected value and taint of one operation
    function automatic taint_pkg::taint_word_t model_word(taint_pkg::taint_op_t o);
        taint_pkg::taint_word_t r;
        logic [w-1:0]           ut;
        logic [31:0]            prod;
        int                     amt;
        r = '0;
        ut = o.a_taint | o.b_taint;
        amt = int'(o.b & amt_mask);
        case (o.op)
            taint_pkg::op_not: begin
                r.value = ~o.a;
                r.taint = o.a_taint;
            end
            taint_pkg::op_and: begin
                r.value = o.a & o.b;
                r.taint = (o.a_taint & o.b) | (o.b_taint & o.a) | (o.a_taint & o.b_taint);
            end
            taint_pkg::op_or: begin
                r.value = o.a | o.b;
                r.taint = (o.a_taint & ~o.b) | (o.b_taint & ~o.a) | (o.a_taint & o.b_taint);
            end
            taint_pkg::op_xor: begin
                r.value = o.a ^ o.b;
                r.taint = ut;
            end
            taint_pkg::op_eq: begin
                r.value[0] = (o.a == o.b);
                // any untainted disagreement decides the compare
                r.taint[0] = (ut != '0) && (((o.a ^ o.b) & ~ut) == '0);
            end
            taint_pkg::op_shl, taint_pkg::op_shr, taint_pkg::op_sshr: begin
                if (o.op == taint_pkg::op_shl) begin
                    r.value = o.a << amt;
                    r.taint = o.a_taint << amt;
                end else if (o.op == taint_pkg::op_shr) begin
                    r.value = o.a >> amt;
                    r.taint = o.a_taint >> amt;
                end else begin
                    r.value = shift_arith(o.a, amt);
                    r.taint = shift_arith(o.a_taint, amt);
                end
                if ((o.b_taint & amt_mask) != '0) begin
                    r.taint = '1;
                end
            end
            taint_pkg::op_mul: begin
                prod = o.a * o.b;
                r.value = prod[w-1:0];
                r.taint = (ut != '0) ? '1 : '0;
            end
            taint_pkg::op_logic_not, taint_pkg::op_reduce_or: begin
                r.value[0] = (o.op == taint_pkg::op_logic_not) ? (o.a == '0) : (o.a != '0);
                r.taint[0] = (o.a_taint != '0) && ((o.a & ~o.a_taint) == '0);
            end
            taint_pkg::op_reduce_and: begin
                r.value[0] = (o.a == '1);
                r.taint[0] = (o.a_taint != '0) && ((~o.a & ~o.a_taint) == '0);
            end
            taint_pkg::op_reduce_xor: begin
                r.value[0] = ^o.a;
                r.taint[0] = |o.a_taint;
            end
            taint_pkg::op_mux: begin
                r.value = o.sel ? o.b : o.a;
                r.taint = o.sel ? o.b_taint : o.a_taint;
                if (o.sel_taint) begin
                    r.taint = r.taint | (o.a ^ o.b);
                end
            end
            default: begin
                r.value = o.a;
                r.taint = o.a_taint;
            end
        endcase
        return r;
    endfunction

    function automatic taint_pkg::taint_word_t fold_acc(taint_pkg::taint_word_t q,
            taint_pkg::taint_word_t d, logic commit, logic commit_taint);
        taint_pkg::taint_word_t r;
        r = q;
        if (commit) begin
            r = d;
            if (commit_taint) begin
                r.taint = d.taint | (d.value ^ q.value);
            end
        end else if (commit_taint) begin
            r.taint = q.taint | (d.value ^ q.value);
        end
        return r;
    endfunction

    function automatic taint_pkg::taint_op_t rand_op(taint_pkg::taint_op_e code);
        taint_pkg::taint_op_t o;
        logic [31:0]          r;
        r = next_rand();
        o = '0;
        o.op = code;
        o.a = rand_word();
        o.b = rand_word();
        o.sel = r[0];
        o.commit = r[1];
        return o;
    endfunction

    task automatic check_word(string name, taint_pkg::taint_word_t got,
            taint_pkg::taint_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s value=%h taint=%h expected value=%h taint=%h at %0t",
                     name, got.value, got.taint, exp.value, exp.taint, $time);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s=%h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // results are compared mid cycle, away from the clock edge
    always @(negedge pos_clk) begin
        if (res_valid) begin
            if (exp_res_q.size() == 0) begin
                protocol_errors++;
                $display("res_valid pulsed with no operation outstanding at %0t", $time);
            end else begin
                check_word("res", res, exp_res_q.pop_front());
                check_word("acc", acc, exp_acc_q.pop_front());
            end
        end
    end

    task automatic issue_op(taint_pkg::taint_op_t o);
        taint_pkg::taint_word_t exp;
        exp = model_word(o);
        model_acc = fold_acc(model_acc, exp, o.commit, o.commit_taint);
        exp_res_q.push_back(exp);
        exp_acc_q.push_back(model_acc);
        op = o;
        op_valid = 1'b1;
        @(posedge pos_clk);
        #1;
        op_valid = 1'b0;
    endtask

    task automatic issue_unary(taint_pkg::taint_op_e code, logic [w-1:0] a,
            logic [w-1:0] a_taint);
        taint_pkg::taint_op_t o;
        o = '0;
        o.op = code;
        o.a = a;
        o.a_taint = a_taint;
        issue_op(o);
    endtask

    task automatic drain();
        while (exp_res_q.size() != 0) begin
            @(negedge pos_clk);
        end
        @(posedge pos_clk);
        #1;
    endtask

    task automatic apply_reset();
        pos_arst = 1'b1;
        op_valid = 1'b0;
        exp_res_q.delete();
        exp_acc_q.delete();
        model_acc = '0;
        repeat (4) @(posedge pos_clk);
        #1;
        pos_arst = 1'b0;
    endtask

    task automatic test_untainted();
        for (int k = 0; k < 15; k++) begin
            for (int n = 0; n < 4; n++) begin
                issue_op(rand_op(taint_pkg::taint_op_e'(4'(k))));
            end
        end
        drain();
    endtask

    task automatic test_binary_taint();
        taint_pkg::taint_op_e bin_codes [5];
        taint_pkg::taint_op_e sh_codes [3];
        taint_pkg::taint_op_t o;
        bin_codes = '{taint_pkg::op_and, taint_pkg::op_or, taint_pkg::op_xor,
                      taint_pkg::op_eq, taint_pkg::op_mul};
        sh_codes = '{taint_pkg::op_shl, taint_pkg::op_shr, taint_pkg::op_sshr};
        for (int k = 0; k < 5; k++) begin
            for (int n = 0; n < 8; n++) begin
                o = rand_op(bin_codes[k]);
                o.a_taint = rand_word() & rand_word();
                o.b_taint = rand_word() & rand_word();
                // equal operands, then operands that differ only under taint
                if (n == 0) begin
                    o.b = o.a;
                end else if (n == 1) begin
                    o.b = o.a ^ (o.a_taint | o.b_taint);
                end
                issue_op(o);
            end
        end
        for (int k = 0; k < 3; k++) begin
            for (int n = 0; n < 4; n++) begin
                o = rand_op(sh_codes[k]);
                o.a_taint = rand_word();
                if (n < 2) begin
                    o.b_taint = {{(w-1){1'b0}}, 1'b1} << n;
                end else begin
                    o.b_taint = rand_word() & ~amt_mask;
                end
                issue_op(o);
            end
        end
        drain();
    endtask

    task automatic test_reduce();
        taint_pkg::taint_op_e red_codes [4];
        taint_pkg::taint_op_t o;
        red_codes = '{taint_pkg::op_logic_not, taint_pkg::op_reduce_or,
                      taint_pkg::op_reduce_and, taint_pkg::op_reduce_xor};
        issue_unary(taint_pkg::op_reduce_or, 16'h0000, 16'h0010);
        // untainted 1 masks the taint
        issue_unary(taint_pkg::op_reduce_or, 16'h0100, 16'h0010);
        issue_unary(taint_pkg::op_reduce_or, 16'h0010, 16'h0010);
        issue_unary(taint_pkg::op_logic_not, 16'h0000, 16'h8001);
        issue_unary(taint_pkg::op_logic_not, 16'h0002, 16'h8001);
        issue_unary(taint_pkg::op_reduce_and, 16'hffef, 16'h0010);
        // untainted 0 masks the taint
        issue_unary(taint_pkg::op_reduce_and, 16'hfeef, 16'h0010);
        issue_unary(taint_pkg::op_reduce_and, 16'hffff, 16'h0000);
        issue_unary(taint_pkg::op_reduce_xor, 16'h1234, 16'h0200);
        for (int n = 0; n < 15; n++) begin
            o = rand_op(red_codes[n % 4]);
            o.a_taint = rand_word() & rand_word();
            if (n % 2 == 0) begin
                o.a = (o.op == taint_pkg::op_reduce_and) ? (o.a | ~o.a_taint)
                                                         : (o.a & o.a_taint);
            end
            issue_op(o);
        end
        drain();
    endtask

    task automatic test_mux();
        taint_pkg::taint_op_t o;
        for (int n = 0; n < 16; n++) begin
            o = rand_op(taint_pkg::op_mux);
            o.a_taint = rand_word() & rand_word();
            o.b_taint = rand_word() & rand_word();
            o.sel = n[0];
            o.sel_taint = n[1];
            issue_op(o);
        end
        drain();
    endtask

    // back to back, so the fold sees every in-flight result in order
    task automatic test_fold();
        taint_pkg::taint_op_t o;
        logic [31:0]          r;
        for (int n = 0; n < 24; n++) begin
            r = next_rand();
            o = rand_op(taint_pkg::taint_op_e'(4'(r % 15)));
            o.a_taint = rand_word() & rand_word() & rand_word();
            o.b_taint = rand_word() & rand_word() & rand_word();
            o.commit = (n % 4 < 2);
            o.commit_taint = (n % 4 == 1) || (n % 4 == 2);
            issue_op(o);
        end
        drain();
    endtask

    task automatic test_reset();
        taint_pkg::taint_op_t   o;
        taint_pkg::taint_word_t zero_word;
        zero_word = '0;
        for (int n = 0; n < 6; n++) begin
            o = rand_op(taint_pkg::op_or);
            o.a_taint = rand_word();
            o.commit = 1'b1;
            issue_op(o);
        end
        // two ops still in flight
        pos_arst = 1'b1;
        #1;
        check_bit("res_valid", res_valid, 1'b0);
        check_word("res", res, zero_word);
        check_word("acc", acc, zero_word);
        apply_reset();
        issue_op(rand_op(taint_pkg::op_xor));
        issue_op(rand_op(taint_pkg::op_mul));
        drain();
    endtask

    initial begin
        pos_arst = 1'b1;
        op_valid = 1'b0;
        op = '0;
        model_acc = '0;
        apply_reset();
        test_untainted();
        test_binary_taint();
        test_reduce();
        test_mux();
        test_fold();
        test_reset();
        $display("errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // every op plus room for drains and resets
    initial begin
        #((total_ops + 200) * clk_period);
        $display("timeout: operations did not complete in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/taint_unit_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module taint_unit_checker (
    input wire logic                   pos_clk,
    input wire logic                   pos_arst,
    input wire logic                   op_valid,
    input wire taint_pkg::taint_op_t   op,
    input wire logic                   res_valid,
    input wire taint_pkg::taint_word_t res
);

    logic op_clean;

    // no taint anywhere on the request
    assign op_clean = (op.a_taint == '0) && (op.b_taint == '0) &&
                      !op.sel_taint && !op.commit_taint;

    res_valid_latency: assert property (@(posedge pos_clk) disable iff (pos_arst)
        res_valid == $past(op_valid, 2))
        else $error("res_valid does not follow op_valid by two cycles");

    res_valid_after_reset: assert property (@(posedge pos_clk)
        $fell(pos_arst) |-> !res_valid)
        else $error("res_valid high in the first cycle after reset");

    clean_op_clean_result: assert property (@(posedge pos_clk) disable iff (pos_arst)
        (res_valid && $past(op_clean, 2)) |-> (res.taint == '0))
        else $error("result taint set for an operation without taint inputs");

endmodule

bind taint_unit taint_unit_checker i_taint_unit_checker (
    .pos_clk   (pos_clk),
    .pos_arst  (pos_arst),
    .op_valid  (op_valid),
    .op        (op),
    .res_valid (res_valid),
    .res       (res)
);

`default_nettype wire

/* logic/taint_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module taint_unit #(
    parameter int data_width = taint_pkg::data_width_default
) (
    input  wire logic                 pos_clk,
    input  wire logic                 pos_arst,
    input  wire logic                 op_valid,
    input  wire taint_pkg::taint_op_t op,
    output logic                      res_valid,
    output taint_pkg::taint_word_t    res,
    output taint_pkg::taint_word_t    acc
);

    logic                   dec_valid;
    taint_pkg::taint_op_t   dec_op;
    taint_pkg::taint_ctrl_t dec_ctrl;
    taint_pkg::taint_word_t exe_word;

    // stage 1, request register and opcode decode
    taint_decode #(
        .data_width (data_width)
    ) i_taint_decode (
        .pos_clk   (pos_clk),
        .pos_arst  (pos_arst),
        .op_valid  (op_valid),
        .op        (op),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_ctrl  (dec_ctrl)
    );

    taint_execute #(
        .data_width (data_width)
    ) i_taint_execute (
        .dec_op   (dec_op),
        .dec_ctrl (dec_ctrl),
        .exe_word (exe_word)
    );

    // stage 2, result and accumulator
    taint_result #(
        .data_width (data_width)
    ) i_taint_result (
        .pos_clk   (pos_clk),
        .pos_arst  (pos_arst),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .exe_word  (exe_word),
        .res_valid (res_valid),
        .res       (res),
        .acc       (acc)
    );

endmodule

`default_nettype wire

/* logic/taint_result.sv */
`timescale 1ns/100ps
`default_nettype none

module taint_result #(
    parameter int data_width = taint_pkg::data_width_default
) (
    input  wire logic                   pos_clk,
    input  wire logic                   pos_arst,
    input  wire logic                   dec_valid,
    input  wire taint_pkg::taint_op_t   dec_op,
    input  wire taint_pkg::taint_word_t exe_word,
    output logic                        res_valid,
    output taint_pkg::taint_word_t      res,
    output taint_pkg::taint_word_t      acc
);

    // bits where a tainted enable could have changed the stored value
    logic [data_width-1:0] fold_diff;

    taint_pkg::taint_word_t acc_next;

    assign fold_diff = exe_word.value ^ acc.value;

    // enabled flip-flop taint rule
    always_comb begin
        acc_next = acc;
        if (dec_op.commit) begin
            acc_next.value = exe_word.value;
            acc_next.taint = exe_word.taint;
            if (dec_op.commit_taint) begin
                acc_next.taint = exe_word.taint | fold_diff;
            end
        end else if (dec_op.commit_taint) begin
            // value held, taint grows where it might have loaded
            acc_next.taint = acc.taint | fold_diff;
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= dec_valid;
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            res <= '0;
            acc <= '0;
        end else if (dec_valid) begin
            res <= exe_word;
            acc <= acc_next;
        end
    end

endmodule

`default_nettype wire

/* logic/taint_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module taint_execute #(
    parameter int data_width = taint_pkg::data_width_default
) (
    input  wire taint_pkg::taint_op_t   dec_op,
    input  wire taint_pkg::taint_ctrl_t dec_ctrl,
    output taint_pkg::taint_word_t      exe_word
);

    // shift amount is the low log2 bits of b
    localparam int amt_width = (data_width > 1) ? $clog2(data_width) : 1;

    logic [data_width-1:0] a;
    logic [data_width-1:0] at;
    logic [data_width-1:0] b;
    logic [data_width-1:0] bt;
    logic [data_width-1:0] ab_taint;
    logic [data_width-1:0] product;
    logic [amt_width-1:0]  sh_amt;
    logic                  amt_tainted;
    logic                  red_invert;
    logic [data_width-1:0] sh_value;
    logic [data_width-1:0] sh_taint;

    taint_pkg::taint_word_t un_word;
    taint_pkg::taint_word_t bin_word;
    taint_pkg::taint_word_t red_word;
    taint_pkg::taint_word_t sh_word;
    taint_pkg::taint_word_t mux_word;

    assign a  = dec_op.a;
    assign at = dec_op.a_taint;
    assign b  = dec_op.b;
    assign bt = dec_op.b_taint;

    assign ab_taint    = at | bt;
    // low half only
    assign product     = a * b;
    assign sh_amt      = b[amt_width-1:0];
    assign amt_tainted = |bt[amt_width-1:0];
    assign red_invert  = (dec_op.op == taint_pkg::op_logic_not);

    // copy and not keep the operand taint as is
    always_comb begin
        un_word.value = a;
        un_word.taint = at;
        if (dec_ctrl.cell_class == taint_pkg::cell_not) begin
            un_word.value = ~a;
        end
    end

    always_comb begin
        bin_word = '0;
        case (dec_ctrl.cell_class)
            taint_pkg::cell_and: begin
                bin_word.value = a & b;
                // a tainted bit matters only where the other side is 1
                bin_word.taint = (at & b) | (bt & a) | (at & bt);
            end
            taint_pkg::cell_or: begin
                bin_word.value = a | b;
                bin_word.taint = (at & ~b) | (bt & ~a) | (at & bt);
            end
            taint_pkg::cell_eq: begin
                bin_word.value[0] = (a == b);
                // untainted bits already disagree, so the compare is fixed
                bin_word.taint[0] = (|ab_taint) &&
                                    ((a & ~ab_taint) == (b & ~ab_taint));
            end
            taint_pkg::cell_mul: begin
                bin_word.value = product;
                bin_word.taint = {data_width{|ab_taint}};
            end
            // xor and anything else take the union
            default: begin
                bin_word.value = a ^ b;
                bin_word.taint = ab_taint;
            end
        endcase
    end

    // reduce results live in bit 0
    always_comb begin
        red_word = '0;
        case (dec_ctrl.cell_class)
            taint_pkg::cell_reduce_and: begin
                red_word.value[0] = &a;
                // an untainted 0 pins the result
                red_word.taint[0] = (&(at | a)) & (|at);
            end
            taint_pkg::cell_reduce_xor: begin
                red_word.value[0] = ^a;
                red_word.taint[0] = |at;
            end
            default: begin
                red_word.value[0] = red_invert ^ (|a);
                // an untainted 1 pins the result
                red_word.taint[0] = (|at) & ~(|(a & ~at));
            end
        endcase
    end

    always_comb begin
        case (dec_ctrl.shift_kind)
            taint_pkg::shift_left: begin
                sh_value = a << sh_amt;
                sh_taint = at << sh_amt;
            end
            taint_pkg::shift_right: begin
                sh_value = a >> sh_amt;
                sh_taint = at >> sh_amt;
            end
            default: begin
                sh_value = $unsigned($signed(a) >>> sh_amt);
                sh_taint = $unsigned($signed(at) >>> sh_amt);
            end
        endcase
        sh_word.value = sh_value;
        sh_word.taint = amt_tainted ? {data_width{1'b1}} : sh_taint;
    end

    always_comb begin
        mux_word.value = dec_op.sel ? b : a;
        mux_word.taint = dec_op.sel ? bt : at;
        // tainted select differs wherever the two inputs differ
        if (dec_op.sel_taint) begin
            mux_word.taint = mux_word.taint | (a ^ b);
        end
    end

    always_comb begin
        if (dec_ctrl.use_mux) begin
            exe_word = mux_word;
        end else if (dec_ctrl.shift_kind != taint_pkg::shift_none) begin
            exe_word = sh_word;
        end else if (dec_ctrl.reduce) begin
            exe_word = red_word;
        end else if (dec_ctrl.unary) begin
            exe_word = un_word;
        end else begin
            exe_word = bin_word;
        end
    end

endmodule

`default_nettype wire

/* logic/taint_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module taint_decode #(
    parameter int data_width = taint_pkg::data_width_default
) (
    input  wire logic                   pos_clk,
    input  wire logic                   pos_arst,
    input  wire logic                   op_valid,
    input  wire taint_pkg::taint_op_t   op,
    output logic                        dec_valid,
    output taint_pkg::taint_op_t        dec_op,
    output taint_pkg::taint_ctrl_t      dec_ctrl
);

    taint_pkg::taint_ctrl_t ctrl_next;
    taint_pkg::taint_op_t   op_next;

    // opcode to cell controls
    always_comb begin
        ctrl_next = '0;
        case (op.op)
            taint_pkg::op_pass: begin
                ctrl_next.unary = 1'b1;
            end
            taint_pkg::op_not: begin
                ctrl_next.unary      = 1'b1;
                ctrl_next.cell_class = taint_pkg::cell_not;
            end
            taint_pkg::op_and: ctrl_next.cell_class = taint_pkg::cell_and;
            taint_pkg::op_or:  ctrl_next.cell_class = taint_pkg::cell_or;
            taint_pkg::op_xor: ctrl_next.cell_class = taint_pkg::cell_xor;
            taint_pkg::op_eq:  ctrl_next.cell_class = taint_pkg::cell_eq;
            taint_pkg::op_mul: ctrl_next.cell_class = taint_pkg::cell_mul;
            taint_pkg::op_shl:  ctrl_next.shift_kind = taint_pkg::shift_left;
            taint_pkg::op_shr:  ctrl_next.shift_kind = taint_pkg::shift_right;
            taint_pkg::op_sshr: ctrl_next.shift_kind = taint_pkg::shift_arith;
            // logic_not shares the reduce_or taint rule
            taint_pkg::op_logic_not, taint_pkg::op_reduce_or: begin
                ctrl_next.unary      = 1'b1;
                ctrl_next.reduce     = 1'b1;
                ctrl_next.cell_class = taint_pkg::cell_reduce_any;
            end
            taint_pkg::op_reduce_and: begin
                ctrl_next.unary      = 1'b1;
                ctrl_next.reduce     = 1'b1;
                ctrl_next.cell_class = taint_pkg::cell_reduce_and;
            end
            taint_pkg::op_reduce_xor: begin
                ctrl_next.unary      = 1'b1;
                ctrl_next.reduce     = 1'b1;
                ctrl_next.cell_class = taint_pkg::cell_reduce_xor;
            end
            taint_pkg::op_mux: ctrl_next.use_mux = 1'b1;
            // unknown opcode behaves as a plain copy
            default: ctrl_next.unary = 1'b1;
        endcase
    end

    // unary cells never look at b, keep it quiet downstream
    always_comb begin
        op_next = op;
        if (ctrl_next.unary) begin
            op_next.b       = {data_width{1'b0}};
            op_next.b_taint = {data_width{1'b0}};
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= op_valid;
        end
    end

    always_ff @(posedge pos_clk) begin
        if (op_valid) begin
            dec_op   <= op_next;
            dec_ctrl <= ctrl_next;
        end
    end

endmodule

`default_nettype wire

/* logic/taint_pkg.sv */
`default_nettype none

package taint_pkg;

    // operand width of every struct below
    localparam int data_width_default = 16;

    typedef enum logic [3:0] {
        op_pass       = 4'd0,
        op_not        = 4'd1,
        op_and        = 4'd2,
        op_or         = 4'd3,
        op_xor        = 4'd4,
        op_eq         = 4'd5,
        op_shl        = 4'd6,
        op_shr        = 4'd7,
        op_sshr       = 4'd8,
        op_mul        = 4'd9,
        op_logic_not  = 4'd10,
        op_reduce_or  = 4'd11,
        op_reduce_and = 4'd12,
        op_reduce_xor = 4'd13,
        op_mux        = 4'd14
    } taint_op_e;

    // one request, operands each paired with a taint shadow
    typedef struct packed {
        taint_op_e                     op;
        logic [data_width_default-1:0] a;
        logic [data_width_default-1:0] a_taint;
        logic [data_width_default-1:0] b;
        logic [data_width_default-1:0] b_taint;
        logic                          sel;
        logic                          sel_taint;
        logic                          commit;
        logic                          commit_taint;
    } taint_op_t;

    typedef enum logic [1:0] {
        shift_none  = 2'd0,
        shift_left  = 2'd1,
        shift_right = 2'd2,
        shift_arith = 2'd3
    } taint_shift_e;

    typedef enum logic [3:0] {
        cell_copy       = 4'd0,
        cell_not        = 4'd1,
        cell_and        = 4'd2,
        cell_or         = 4'd3,
        cell_xor        = 4'd4,
        cell_eq         = 4'd5,
        cell_mul        = 4'd6,
        cell_reduce_and = 4'd7,
        cell_reduce_any = 4'd8,
        cell_reduce_xor = 4'd9
    } taint_cell_e;

    typedef struct packed {
        logic         unary;
        logic         reduce;
        taint_shift_e shift_kind;
        logic         use_mux;
        taint_cell_e  cell_class;
    } taint_ctrl_t;

    typedef struct packed {
        logic [data_width_default-1:0] value;
        logic [data_width_default-1:0] taint;
    } taint_word_t;

endpackage

`default_nettype wire
